/* design/iomem_pkg.sv */
`default_nettype none

package iomem_pkg;

  ////////////////////////////////////////
  // Address map
  ////////////////////////////////////////

  // RAM region, bits outside the mask must equal the base
  localparam logic [31:0] RAM_BASE = 32'h4000_0000;
  localparam logic [31:0] RAM_MASK = 32'h000F_FFFF;

  localparam logic [31:0] TIMER_LO_ADDR = 32'h3000_0000;
  localparam logic [31:0] TIMER_HI_ADDR = 32'h3000_0004;

  ////////////////////////////////////////
  // Sizes and timing
  ////////////////////////////////////////

  localparam int RAM_WORDS   = 1024;
  localparam int RAM_AW      = 10;
  // Cycles from first valid cycle to ready
  localparam int RAM_LATENCY = 4;
  localparam int LAT_CNT_W   = $clog2(RAM_LATENCY + 1);

  // Serial loader line
  localparam int         CLKS_PER_BIT    = 8;
  localparam int         UART_CNT_W      = $clog2(CLKS_PER_BIT);
  localparam logic [7:0] PROG_START_BYTE = 8'hA5;

  ////////////////////////////////////////
  // Bus and RAM port types
  ////////////////////////////////////////

  // Zero wstrb means read
  typedef struct packed {
    logic        valid;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } iomem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } iomem_rsp_t;

  typedef struct packed {
    logic              rd_en;
    logic [3:0]        wstrb;
    logic [RAM_AW-1:0] index;
    logic [31:0]       wdata;
  } ram_req_t;

endpackage

`default_nettype wire

/* design/iomem_decoder.sv */
`default_nettype none

module iomem_decoder import iomem_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n,
  input  iomem_req_t  bus_req_i,
  output iomem_rsp_t  bus_rsp_o,
  input  logic        prog_mode_i,
  input  ram_req_t    loader_req_i,
  output ram_req_t    ram_req_o,
  input  logic [31:0] ram_rdata_i,
  input  logic [31:0] timer_lo_i,
  input  logic [31:0] timer_hi_i,
  output logic        timer_lo_read_o
);

  logic                 bus_active;
  logic                 hit_ram;
  logic                 hit_lo;
  logic                 hit_hi;
  logic                 is_read;
  logic                 ram_sel;
  logic                 ram_ready;
  logic                 fast_ready;
  logic [LAT_CNT_W-1:0] lat_cnt_q;
  ram_req_t             bus_ram_req;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  // Bus is locked out while the loader owns the RAM
  assign bus_active = bus_req_i.valid & ~prog_mode_i;
  assign hit_ram    = (bus_req_i.addr & ~RAM_MASK) == RAM_BASE;
  assign hit_lo     = bus_req_i.addr == TIMER_LO_ADDR;
  assign hit_hi     = bus_req_i.addr == TIMER_HI_ADDR;
  assign is_read    = bus_req_i.wstrb == 4'b0000;
  assign ram_sel    = bus_active & hit_ram;

  ////////////////////////////////////////
  // RAM latency
  ////////////////////////////////////////

  // Counts cycles of the current RAM request, back to zero after ready
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      lat_cnt_q <= '0;
    end else if (!ram_sel || ram_ready) begin
      lat_cnt_q <= '0;
    end else begin
      lat_cnt_q <= lat_cnt_q + 1'b1;
    end
  end

  assign ram_ready  = ram_sel & (lat_cnt_q == LAT_CNT_W'(RAM_LATENCY));
  // Timer and unmapped space answer at once
  assign fast_ready = bus_active & ~hit_ram;

  assign timer_lo_read_o = bus_active & hit_lo;

  always_comb begin
    // Read one cycle early so the registered RAM output meets ready
    bus_ram_req.rd_en = ram_sel & is_read & (lat_cnt_q == LAT_CNT_W'(RAM_LATENCY - 1));
    bus_ram_req.wstrb = ram_ready ? bus_req_i.wstrb : 4'b0000;
    bus_ram_req.index = bus_req_i.addr[RAM_AW+1:2];
    bus_ram_req.wdata = bus_req_i.wdata;
  end

  // Loader has priority over the bus
  assign ram_req_o = prog_mode_i ? loader_req_i : bus_ram_req;

  always_comb begin
    if (hit_lo) begin
      bus_rsp_o.rdata = timer_lo_i;
    end else if (hit_hi) begin
      bus_rsp_o.rdata = timer_hi_i;
    end else if (hit_ram) begin
      bus_rsp_o.rdata = ram_rdata_i;
    end else begin
      bus_rsp_o.rdata = 32'h0000_0000;
    end
  end

  assign bus_rsp_o.ready = ram_ready | fast_ready;

  // Master keeps a pending request steady until it is accepted
  a_req_held_until_ready: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    bus_req_i.valid && !bus_rsp_o.ready |=> bus_req_i.valid && $stable(bus_req_i));

  // Loader only writes, so no read may reach the RAM during programming
  a_no_ram_read_in_prog: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    prog_mode_i |-> !ram_req_o.rd_en);

endmodule

`default_nettype wire

/* design/byte_ram.sv */
`default_nettype none

module byte_ram import iomem_pkg::*; (
  input  logic        clk_i,
  input  ram_req_t    ram_req_i,
  output logic [31:0] rdata_o
);

  logic [31:0] mem [RAM_WORDS];

  ////////////////////////////////////////
  // Byte lane writes
  ////////////////////////////////////////

  for (genvar lane = 0; lane < 4; lane++) begin : g_lane
    always_ff @(posedge clk_i) begin
      if (ram_req_i.wstrb[lane]) begin
        mem[ram_req_i.index][8*lane +: 8] <= ram_req_i.wdata[8*lane +: 8];
      end
    end
  end

  ////////////////////////////////////////
  // Registered read
  ////////////////////////////////////////

  // Output holds its value between reads
  always_ff @(posedge clk_i) begin
    if (ram_req_i.rd_en) begin
      rdata_o <= mem[ram_req_i.index];
    end
  end

endmodule

`default_nettype wire

/* design/cycle_timer.sv */
`default_nettype none

module cycle_timer (
  input  logic        clk_i,
  input  logic        sys_rst_n_i,
  input  logic        lo_read_i,
  output logic [31:0] lo_o,
  output logic [31:0] hi_o
);

  logic [63:0] count_q;
  logic [31:0] hi_snap_q;

  always_ff @(posedge clk_i) begin
    if (!sys_rst_n_i) begin
      count_q <= 64'h0;
    end else begin
      count_q <= count_q + 64'h1;
    end
  end

  // Upper half frozen at the low read, keeps the pair coherent
  always_ff @(posedge clk_i) begin
    if (!sys_rst_n_i) begin
      hi_snap_q <= 32'h0;
    end else if (lo_read_i) begin
      hi_snap_q <= count_q[63:32];
    end
  end

  assign lo_o = count_q[31:0];
  assign hi_o = hi_snap_q;

endmodule

`default_nettype wire

/* design/uart_rx.sv */
`default_nettype none

module uart_rx import iomem_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n,
  input  logic       rx_i,
  output logic [7:0] byte_o,
  output logic       byte_valid_o
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t             state_q;
  logic [1:0]            sync_q;
  logic                  rx_prev_q;
  logic [UART_CNT_W-1:0] clk_cnt_q;
  logic [2:0]            bit_idx_q;
  logic [7:0]            shift_q;
  logic                  valid_q;
  logic                  rx_sync;
  logic                  bit_done;

  assign rx_sync  = sync_q[1];
  assign bit_done = clk_cnt_q == UART_CNT_W'(CLKS_PER_BIT - 1);

  // Two flop synchronizer, idle line is high
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      sync_q    <= 2'b11;
      rx_prev_q <= 1'b1;
    end else begin
      sync_q    <= {sync_q[0], rx_i};
      rx_prev_q <= rx_sync;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_q   <= RX_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= 3'd0;
      valid_q   <= 1'b0;
    end else begin
      valid_q   <= 1'b0;
      clk_cnt_q <= clk_cnt_q + 1'b1;
      case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          if (rx_prev_q && !rx_sync) begin
            state_q <= RX_START;
          end
        end
        // Half a bit in, the start bit must still be low
        RX_START: begin
          if (clk_cnt_q == UART_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
            clk_cnt_q <= '0;
            bit_idx_q <= 3'd0;
            state_q   <= rx_sync ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_done) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end
        end
        default: begin
          // Low stop bit drops the frame
          if (bit_done) begin
            valid_q <= rx_sync;
            state_q <= RX_IDLE;
          end
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && bit_done) begin
      shift_q <= {rx_sync, shift_q[7:1]};
    end
  end

  assign byte_o       = shift_q;
  assign byte_valid_o = valid_q;

endmodule

`default_nettype wire

/* design/prog_loader.sv */
`default_nettype none

module prog_loader import iomem_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n,
  input  logic [7:0] byte_i,
  input  logic       byte_valid_i,
  output logic       prog_mode_o,
  output logic       sys_rst_n_o,
  output ram_req_t   ram_req_o
);

  typedef enum logic [2:0] {
    LD_IDLE,
    LD_CNT_LO,
    LD_CNT_HI,
    LD_DATA,
    LD_WRITE
  } ld_state_t;

  ld_state_t   state_q;
  logic [15:0] count_q;
  logic [15:0] word_idx_q;
  logic [1:0]  byte_sel_q;
  logic [31:0] word_q;
  logic        prog_mode_q;
  logic        sys_rst_n_q;

  ////////////////////////////////////////
  // Image parser
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_q     <= LD_IDLE;
      count_q     <= 16'h0000;
      word_idx_q  <= 16'h0000;
      byte_sel_q  <= 2'd0;
      prog_mode_q <= 1'b0;
    end else begin
      case (state_q)
        LD_IDLE: begin
          // Stray bytes are dropped here
          if (byte_valid_i && byte_i == PROG_START_BYTE) begin
            prog_mode_q <= 1'b1;
            state_q     <= LD_CNT_LO;
          end
        end
        LD_CNT_LO: begin
          if (byte_valid_i) begin
            count_q[7:0] <= byte_i;
            state_q      <= LD_CNT_HI;
          end
        end
        LD_CNT_HI: begin
          if (byte_valid_i) begin
            count_q[15:8] <= byte_i;
            word_idx_q    <= 16'h0000;
            byte_sel_q    <= 2'd0;
            if ({byte_i, count_q[7:0]} == 16'h0000) begin
              prog_mode_q <= 1'b0;
              state_q     <= LD_IDLE;
            end else begin
              state_q <= LD_DATA;
            end
          end
        end
        LD_DATA: begin
          if (byte_valid_i) begin
            byte_sel_q <= byte_sel_q + 2'd1;
            if (byte_sel_q == 2'd3) begin
              state_q <= LD_WRITE;
            end
          end
        end
        default: begin
          // Single write cycle, then next word or done
          word_idx_q <= word_idx_q + 16'd1;
          if (word_idx_q + 16'd1 == count_q) begin
            prog_mode_q <= 1'b0;
            state_q     <= LD_IDLE;
          end else begin
            state_q <= LD_DATA;
          end
        end
      endcase
    end
  end

  // Little endian word assembly
  always_ff @(posedge clk_i) begin
    if (state_q == LD_DATA && byte_valid_i) begin
      word_q[8*byte_sel_q +: 8] <= byte_i;
    end
  end

  // Processor side held in reset while loading
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      sys_rst_n_q <= 1'b0;
    end else begin
      sys_rst_n_q <= ~prog_mode_q;
    end
  end

  always_comb begin
    ram_req_o.rd_en = 1'b0;
    ram_req_o.wstrb = (state_q == LD_WRITE) ? 4'b1111 : 4'b0000;
    ram_req_o.index = word_idx_q[RAM_AW-1:0];
    ram_req_o.wdata = word_q;
  end

  assign prog_mode_o = prog_mode_q;
  assign sys_rst_n_o = sys_rst_n_q;

  a_write_only_in_prog: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    (ram_req_o.wstrb != 4'b0000) |-> prog_mode_o);

endmodule

`default_nettype wire

/* design/iomem_subsystem.sv */
`default_nettype none

module iomem_subsystem import iomem_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n,
  input  iomem_req_t bus_req_i,
  output iomem_rsp_t bus_rsp_o,
  input  logic       prog_rx_i,
  output logic       sys_rst_n_o,
  output logic       prog_mode_o
);

  logic        prog_mode;
  logic        sys_rst_n;
  ram_req_t    loader_req;
  ram_req_t    ram_req;
  logic [31:0] ram_rdata;
  logic [31:0] timer_lo;
  logic [31:0] timer_hi;
  logic        timer_lo_read;
  logic [7:0]  rx_byte;
  logic        rx_byte_valid;

  ////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////

  iomem_decoder u_decoder (
    .clk_i           (clk_i),
    .rst_n           (rst_n),
    .bus_req_i       (bus_req_i),
    .bus_rsp_o       (bus_rsp_o),
    .prog_mode_i     (prog_mode),
    .loader_req_i    (loader_req),
    .ram_req_o       (ram_req),
    .ram_rdata_i     (ram_rdata),
    .timer_lo_i      (timer_lo),
    .timer_hi_i      (timer_hi),
    .timer_lo_read_o (timer_lo_read)
  );

  byte_ram u_ram (
    .clk_i     (clk_i),
    .ram_req_i (ram_req),
    .rdata_o   (ram_rdata)
  );

  // Cleared together with the processor
  cycle_timer u_timer (
    .clk_i       (clk_i),
    .sys_rst_n_i (sys_rst_n),
    .lo_read_i   (timer_lo_read),
    .lo_o        (timer_lo),
    .hi_o        (timer_hi)
  );

  ////////////////////////////////////////
  // Program loader
  ////////////////////////////////////////

  uart_rx u_uart_rx (
    .clk_i        (clk_i),
    .rst_n        (rst_n),
    .rx_i         (prog_rx_i),
    .byte_o       (rx_byte),
    .byte_valid_o (rx_byte_valid)
  );

  prog_loader u_loader (
    .clk_i        (clk_i),
    .rst_n        (rst_n),
    .byte_i       (rx_byte),
    .byte_valid_i (rx_byte_valid),
    .prog_mode_o  (prog_mode),
    .sys_rst_n_o  (sys_rst_n),
    .ram_req_o    (loader_req)
  );

  assign prog_mode_o = prog_mode;
  assign sys_rst_n_o = sys_rst_n;

endmodule

`default_nettype wire

/* bench/iomem_tb.sv */
`default_nettype none

module iomem_tb import iomem_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int BUS_TIMEOUT  = 50;
  localparam int LOAD_TIMEOUT = 2000;
  localparam int TIMER_GAP    = 17;
  localparam int RANDOM_OPS   = 200;

  logic       clk;
  logic       rst_n;
  iomem_req_t bus_req;
  iomem_rsp_t bus_rsp;
  logic       prog_rx;
  logic       sys_rst_n;
  logic       prog_mode;

  // Reference memory, known marks words with all four bytes defined
  logic [31:0] model [RAM_WORDS];
  logic        known [RAM_WORDS];

  int   checks = 0;
  int   errors = 0;
  int   timeouts = 0;
  int   cycle_cnt = 0;
  int   load_end_cycle = 0;
  logic saw_prog_mode = 1'b0;
  logic saw_sys_rst_low = 1'b0;

  iomem_subsystem uut (
    .clk_i       (clk),
    .rst_n       (rst_n),
    .bus_req_i   (bus_req),
    .bus_rsp_o   (bus_rsp),
    .prog_rx_i   (prog_rx),
    .sys_rst_n_o (sys_rst_n),
    .prog_mode_o (prog_mode)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Loader side effects seen mid-cycle
  always @(negedge clk) begin
    if (prog_mode) begin
      saw_prog_mode  = 1'b1;
      // Last cycle of programming mode
      load_end_cycle = cycle_cnt;
    end
    if (!sys_rst_n) begin
      saw_sys_rst_low = 1'b1;
    end
  end

  ////////////////////////////////////////
  // Checking and reference model
  ////////////////////////////////////////

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] wdata,
                                              input logic [3:0]  wstrb);
    logic [31:0] result;
    result = old_word;
    for (int lane = 0; lane < 4; lane++) begin
      if (wstrb[lane]) begin
        result[8*lane +: 8] = wdata[8*lane +: 8];
      end
    end
    return result;
  endfunction

  ////////////////////////////////////////
  // Bus master
  ////////////////////////////////////////

  // Holds the request until ready, cycles counts the wait from the first valid cycle
  task automatic bus_access(input logic [31:0] addr, input logic [3:0] wstrb,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output int cycles);
    bit done;
    done   = 1'b0;
    cycles = 0;
    rdata  = 'x;
    bus_req.valid = 1'b1;
    bus_req.wstrb = wstrb;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    while (!done && cycles <= BUS_TIMEOUT) begin
      @(negedge clk);
      if (bus_rsp.ready) begin
        rdata = bus_rsp.rdata;
        done  = 1'b1;
      end else begin
        cycles++;
      end
      @(posedge clk);
      #1;
    end
    bus_req = '0;
    if (!done) begin
      timeouts++;
      $display("Timeout: request to 0x%08h got no ready within %0d cycles", addr, BUS_TIMEOUT);
      cycles = -1;
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [3:0] wstrb,
                           input logic [31:0] wdata, output int cycles);
    logic [31:0] unused_data;
    bus_access(addr, wstrb, wdata, unused_data, cycles);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                          output int cycles);
    bus_access(addr, 4'b0000, 32'h0000_0000, data, cycles);
  endtask

  // Every RAM access also checks the fixed latency
  task automatic ram_write(input string name, input logic [31:0] addr,
                           input logic [3:0] wstrb, input logic [31:0] wdata);
    int                cycles;
    logic [RAM_AW-1:0] idx;
    idx = addr[RAM_AW+1:2];
    bus_write(addr, wstrb, wdata, cycles);
    compare({name, " latency"}, RAM_LATENCY, cycles);
    model[idx] = merge_bytes(model[idx], wdata, wstrb);
    if (wstrb == 4'hF) begin
      known[idx] = 1'b1;
    end
  endtask

  task automatic ram_read_check(input string name, input logic [31:0] addr);
    int                cycles;
    logic [31:0]       data;
    logic [RAM_AW-1:0] idx;
    idx = addr[RAM_AW+1:2];
    bus_read(addr, data, cycles);
    compare({name, " latency"}, RAM_LATENCY, cycles);
    compare(name, model[idx], data);
  endtask

  ////////////////////////////////////////
  // Serial line driver
  ////////////////////////////////////////

  // 8N1 frame, LSB first, then two idle bit times
  task automatic uart_send_byte(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int b = 0; b < 10; b++) begin
      prog_rx = frame[b];
      repeat (CLKS_PER_BIT) @(posedge clk);
      #1;
    end
    prog_rx = 1'b1;
    repeat (2 * CLKS_PER_BIT) @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_ram_strobes();
    logic [31:0] addrs [4];
    logic [3:0]  strobes [4];
    addrs[0]   = RAM_BASE;
    addrs[1]   = RAM_BASE + 32'h44;
    addrs[2]   = RAM_BASE + 32'h3FC;
    addrs[3]   = RAM_BASE + 32'hFFC;
    strobes[0] = 4'b0001;
    strobes[1] = 4'b0110;
    strobes[2] = 4'b1000;
    strobes[3] = 4'b1010;
    for (int i = 0; i < 4; i++) begin
      ram_write("strobe full write", addrs[i], 4'hF, $urandom());
    end
    for (int i = 0; i < 4; i++) begin
      ram_write("strobe partial write", addrs[i], strobes[i], $urandom());
    end
    for (int i = 0; i < 4; i++) begin
      ram_read_check("strobe readback", addrs[i]);
    end
  endtask

  task automatic test_timer();
    logic [31:0] lo1;
    logic [31:0] hi1;
    logic [31:0] lo2;
    logic [31:0] hi2;
    logic [63:0] diff;
    int          cycles;
    bus_read(TIMER_LO_ADDR, lo1, cycles);
    compare("timer lo ready", 32'd0, cycles);
    bus_read(TIMER_HI_ADDR, hi1, cycles);
    compare("timer hi ready", 32'd0, cycles);
    repeat (TIMER_GAP) @(posedge clk);
    #1;
    bus_read(TIMER_LO_ADDR, lo2, cycles);
    bus_read(TIMER_HI_ADDR, hi2, cycles);
    // Low reads are TIMER_GAP plus the two one-cycle reads apart
    diff = {hi2, lo2} - {hi1, lo1};
    compare("timer delta", 32'(TIMER_GAP + 2), diff[31:0]);
    compare("timer delta high", 32'd0, diff[63:32]);
  endtask

  task automatic test_unmapped();
    logic [31:0] data;
    int          cycles;
    ram_write("unmapped setup", RAM_BASE + 32'h10, 4'hF, 32'hCAFE_F00D);
    bus_read(32'h1000_0000, data, cycles);
    compare("unmapped read data", 32'h0000_0000, data);
    compare("unmapped read ready", 32'd0, cycles);
    // Just outside the RAM mask, same low bits as the word above
    bus_write(32'h4010_0010, 4'hF, 32'hDEAD_BEEF, cycles);
    compare("unmapped write ready", 32'd0, cycles);
    ram_read_check("unmapped write ignored", RAM_BASE + 32'h10);
  endtask

  task automatic test_program_load();
    logic [31:0] words [3];
    logic [31:0] lo;
    int          cycles;
    int          wait_cycles;
    int          elapsed;
    words[0] = 32'h1357_9BDF;
    words[1] = 32'h0246_8ACE;
    words[2] = 32'hA5A5_005A;
    saw_prog_mode   = 1'b0;
    saw_sys_rst_low = 1'b0;
    uart_send_byte(8'h3C);
    uart_send_byte(8'h00);
    uart_send_byte(PROG_START_BYTE);
    uart_send_byte(8'h03);
    uart_send_byte(8'h00);
    for (int w = 0; w < 3; w++) begin
      for (int b = 0; b < 4; b++) begin
        uart_send_byte(words[w][8*b +: 8]);
      end
    end
    wait_cycles = 0;
    while (prog_mode && wait_cycles < LOAD_TIMEOUT) begin
      @(posedge clk);
      #1;
      wait_cycles++;
    end
    if (prog_mode) begin
      timeouts++;
      $display("Timeout: loader never left programming mode");
    end
    wait_cycles = 0;
    while (!sys_rst_n && wait_cycles < LOAD_TIMEOUT) begin
      @(posedge clk);
      #1;
      wait_cycles++;
    end
    if (!sys_rst_n) begin
      timeouts++;
      $display("Timeout: system reset was never released after loading");
    end
    compare("load prog_mode raised", 32'd1, 32'(saw_prog_mode));
    compare("load sys_rst_n lowered", 32'd1, 32'(saw_sys_rst_low));
    for (int i = 0; i < 3; i++) begin
      model[i] = words[i];
      known[i] = 1'b1;
      ram_read_check("loaded word", RAM_BASE + 32'(4 * i));
    end
    bus_read(TIMER_LO_ADDR, lo, cycles);
    elapsed = cycle_cnt - load_end_cycle;
    compare("timer cleared by load", 32'd1, 32'(lo <= 32'(elapsed + 8)));
  endtask

  task automatic test_random_traffic();
    logic [31:0] r;
    logic [31:0] ctl;
    logic [31:0] addr;
    logic [3:0]  strobe;
    logic [RAM_AW-1:0] idx;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      r   = $urandom();
      ctl = $urandom();
      // 32 words, upper region bits random so aliases are hit
      addr = RAM_BASE | (r & 32'h000F_F07C);
      idx  = addr[RAM_AW+1:2];
      if (ctl[0] || !known[idx]) begin
        strobe = known[idx] ? ctl[4:1] : 4'hF;
        if (strobe == 4'h0) begin
          strobe = 4'hF;
        end
        ram_write("random write", addr, strobe, $urandom());
      end else begin
        ram_read_check("random read", addr);
      end
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(12731));
    rst_n   = 1'b0;
    bus_req = '0;
    prog_rx = 1'b1;
    for (int i = 0; i < RAM_WORDS; i++) begin
      known[i] = 1'b0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (2) @(posedge clk);
    #1;

    test_ram_strobes();
    test_timer();
    test_unmapped();
    test_program_load();
    test_random_traffic();

    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
design/iomem_pkg.sv
design/iomem_decoder.sv
design/byte_ram.sv
design/cycle_timer.sv
design/uart_rx.sv
design/prog_loader.sv
design/iomem_subsystem.sv
bench/iomem_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module iomem_tb -f all.f -o Viomem_tb

output=$(./obj_dir/Viomem_tb)
echo "$output"

if grep -qx "TEST PASSED" <<< "$output"; then
  exit 0
fi
exit 1
